//--- list.f
+incdir+dv
rtl/mips_isa_pkg.sv
rtl/mips_pipe_pkg.sv
rtl/mips_fetch.sv
rtl/mips_decode.sv
rtl/mips_execute.sv
rtl/mips_writeback.sv
rtl/mips_core.sv
dv/mips_core_tb.sv

//--- Bender.yml
package:
  name: mips_core

sources:
  - rtl/mips_isa_pkg.sv
  - rtl/mips_pipe_pkg.sv
  - rtl/mips_fetch.sv
  - rtl/mips_decode.sv
  - rtl/mips_execute.sv
  - rtl/mips_writeback.sv
  - rtl/mips_core.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/mips_core_tb.sv

//--- dv/mips_program.svh
function automatic instr_t encode_r(funct_t funct, int rd, int rs, int rt);
  return {op_rtype, 5'(rs), 5'(rt), 5'(rd), 5'd0, funct};
endfunction

// Field order as in the assembly form op rt, rs, imm
function automatic instr_t encode_i(opcode_t op, int rt, int rs, int imm);
  return {op, 5'(rs), 5'(rt), 16'(imm)};
endfunction

task automatic emit(instr_t instr);
  imem[reset_pc[7:2] + prog_len] = instr;
  prog_len++;
endtask

task automatic expect_store(string name, word_t addr, word_t data);
  exp_name.push_back(name);
  exp_addr.push_back(addr);
  exp_data.push_back(data);
endtask

task automatic load_program();
  word_t a;
  word_t b;
  word_t r1;
  word_t r2;
  word_t r3;
  word_t r4;
  word_t r5;
  word_t cmp [5];
  for (int i = 0; i < mem_words; i++) begin
    imem[i] = '0;                                  // Bubble
    dmem[i] = 32'hd00d_0000 | word_t'(i << 2);
  end
  a = $urandom;
  b = $urandom;
  dmem[0] = a;
  dmem[1] = b;
  prog_len = 0;
  r1 = 32'd100;
  r2 = word_t'(-7);
  r3 = r1 + r2;
  r4 = r3 - r1;
  r5 = r4 & r3;

  // ----------------------------------------
  // Dependent arithmetic and logic
  // ----------------------------------------
  emit(encode_i(op_addi, 1, 0, 100));
  emit(encode_i(op_addi, 2, 0, -7));
  emit(encode_r(funct_add, 3, 1, 2));              // r2 from memory stage, r1 from writeback
  emit(encode_r(funct_sub, 4, 3, 1));
  emit(encode_r(funct_and, 5, 4, 3));
  emit(encode_r(funct_or, 6, 5, 1));
  emit(encode_i(op_ori, 7, 1, 'h8001));
  emit(encode_i(op_sw, 7, 0, 'h50));               // Store data forwarded
  expect_store("ori zero extend", 32'h50, r1 | 32'h0000_8001);
  for (int k = 0; k < 4; k++) begin
    emit(encode_i(op_sw, 3 + k, 0, 'h40 + 4 * k));
  end
  expect_store("add", 32'h40, r3);
  expect_store("sub", 32'h44, r4);
  expect_store("and", 32'h48, r5);
  expect_store("or", 32'h4c, r5 | r1);

  // Signed and unsigned compares
  emit(encode_r(funct_slt, 8, 2, 1));
  emit(encode_r(funct_sltu, 9, 2, 1));
  emit(encode_i(op_slti, 10, 2, -3));
  emit(encode_i(op_slti, 11, 1, -3));
  emit(encode_r(funct_sltu, 12, 1, 2));
  cmp[0] = ($signed(r2) < $signed(r1)) ? 32'd1 : 32'd0;
  cmp[1] = (r2 < r1) ? 32'd1 : 32'd0;
  cmp[2] = ($signed(r2) < -32'sd3) ? 32'd1 : 32'd0;
  cmp[3] = ($signed(r1) < -32'sd3) ? 32'd1 : 32'd0;
  cmp[4] = (r1 < r2) ? 32'd1 : 32'd0;
  for (int k = 0; k < 5; k++) begin
    emit(encode_i(op_sw, 8 + k, 0, 'h54 + 4 * k));
    expect_store($sformatf("compare %0d", k), 32'h54 + 4 * k, cmp[k]);
  end

  // Load followed by a dependent add
  emit(encode_i(op_lw, 13, 0, 0));
  emit(encode_i(op_lw, 14, 0, 4));
  emit(encode_r(funct_add, 15, 13, 14));
  emit(encode_i(op_sw, 15, 0, 'h68));
  expect_store("load use add", 32'h68, a + b);

  // ----------------------------------------
  // Branches skip marker stores at 0x80 and up
  // ----------------------------------------
  emit(encode_i(op_beq, 1, 1, 2));                 // Taken
  emit(encode_i(op_sw, 1, 0, 'h80));
  emit(encode_i(op_sw, 1, 0, 'h84));
  emit(encode_i(op_bne, 2, 1, 2));                 // Taken
  emit(encode_i(op_sw, 2, 0, 'h88));
  emit(encode_i(op_sw, 2, 0, 'h8c));
  emit(encode_i(op_beq, 2, 1, 2));                 // Not taken
  emit(encode_i(op_sw, 1, 0, 'h6c));
  emit(encode_i(op_bne, 1, 1, 2));                 // Not taken
  emit(encode_i(op_sw, 2, 0, 'h70));
  expect_store("beq not taken", 32'h6c, r1);
  expect_store("bne not taken", 32'h70, r2);

  // r17 is read in decode while it sits in writeback
  emit(encode_i(op_addi, 17, 0, 'h123));
  emit(encode_i(op_ori, 18, 0, 1));
  emit(encode_i(op_ori, 19, 0, 2));
  emit(encode_r(funct_add, 20, 17, 0));
  emit(encode_i(op_sw, 20, 0, 'h74));
  expect_store("write through", 32'h74, 32'h0000_0123);

  loop_pc = reset_pc + (word_t'(prog_len) << 2);
  emit(encode_i(op_beq, 0, 0, -1));                // Self-branch loop
endtask

//--- dv/mips_core_tb.sv
`timescale 1ns/1ps

module mips_core_tb
  import mips_isa_pkg::*;
();

  localparam word_t reset_pc     = 32'h0000_0020;
  localparam int    clk_period   = 8;
  localparam int    drive_delay  = 1;
  localparam int    reset_cycles = 5;
  localparam int    mem_words    = 64;   // Word index from address bits 7:2 in both memories

  logic   clk = 1'b0;
  logic   reset;
  word_t  imem_addr;
  instr_t imem_data;
  word_t  dmem_addr;
  word_t  dmem_wdata;
  logic   dmem_write;
  word_t  dmem_rdata;

  instr_t imem [mem_words];
  word_t  dmem [mem_words];
  int     prog_len;
  word_t  loop_pc;                       // Address of the final self-branch

  // Expected stores in program order
  string  exp_name [$];
  word_t  exp_addr [$];
  word_t  exp_data [$];

  task automatic stop_on_error(string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "run stopped on first error");
  endtask

  `include "mips_program.svh"

  mips_core #(
    .reset_pc (reset_pc)
  ) dut0 (
    .clk        (clk),
    .reset      (reset),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_write (dmem_write),
    .dmem_rdata (dmem_rdata)
  );

  always #(clk_period / 2) clk = ~clk;

  // ----------------------------------------
  // Memory models
  // ----------------------------------------
  assign imem_data  = imem[imem_addr[7:2]];
  assign dmem_rdata = dmem[dmem_addr[7:2]];   // Same-cycle read

  always @(negedge clk) begin
    if (!reset && dmem_write) begin
      dmem[dmem_addr[7:2]] <= dmem_wdata;
    end
  end

  task automatic check_idle(string name);
    assert (imem_addr == reset_pc) else
      stop_on_error($sformatf("mismatch %s imem_addr expected %h actual %h",
                              name, reset_pc, imem_addr));
    assert (dmem_write === 1'b0) else
      stop_on_error($sformatf("mismatch %s dmem_write expected 0 actual %b",
                              name, dmem_write));
  endtask

  always @(negedge clk) begin
    if (reset === 1'b1) begin
      check_idle("reset");
    end
  end

  // ----------------------------------------
  // Store checker
  // ----------------------------------------
  always @(negedge clk) begin
    if (!reset && dmem_write) begin
      assert (exp_addr.size() != 0) else
        stop_on_error($sformatf("store to address %h after all expected stores were seen",
                                dmem_addr));
      assert (dmem_addr == exp_addr[0]) else
        stop_on_error($sformatf("mismatch %s address expected %h actual %h",
                                exp_name[0], exp_addr[0], dmem_addr));
      assert (dmem_wdata == exp_data[0]) else
        stop_on_error($sformatf("mismatch %s data expected %h actual %h",
                                exp_name[0], exp_data[0], dmem_wdata));
      void'(exp_name.pop_front());
      void'(exp_addr.pop_front());
      void'(exp_data.pop_front());
    end
  end

  // Main sequence
  initial begin
    reset = 1'b1;
    void'($urandom(68));
    load_program();
    repeat (reset_cycles) @(posedge clk);
    #drive_delay;
    reset = 1'b0;
    @(negedge clk);
    check_idle("first cycle after reset");
    while (exp_addr.size() != 0 || imem_addr != loop_pc) begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk);          // Catch any late stray store
    $display(">>> PASS");
    $finish;
  end

  // Watchdog allows four cycles per instruction plus some slack
  initial begin
    @(negedge reset);
    repeat (prog_len * 4 + 20) @(posedge clk);
    stop_on_error($sformatf("timeout: %0d expected stores did not appear within %0d cycles",
                            exp_addr.size(), prog_len * 4 + 20));
  end

endmodule

//--- rtl/mips_core.sv
`timescale 1ns/1ps

module mips_core
  import mips_isa_pkg::*, mips_pipe_pkg::*;
#(
  parameter word_t reset_pc = '0
) (
  input  logic   clk,
  input  logic   reset,
  output word_t  imem_addr,
  input  instr_t imem_data,
  output word_t  dmem_addr,
  output word_t  dmem_wdata,
  output logic   dmem_write,
  input  word_t  dmem_rdata
);

  if_id_t    if_id;
  id_ex_t    id_ex;
  ex_mem_t   ex_mem;
  wb_port_t  wb;
  redirect_t redirect;
  logic      stall;

  // ----------------------------------------
  // Input side
  // ----------------------------------------
  mips_fetch #(
    .reset_pc (reset_pc)
  ) fetch0 (
    .clk       (clk),
    .reset     (reset),
    .stall     (stall),
    .redirect  (redirect),
    .imem_data (imem_data),
    .imem_addr (imem_addr),
    .if_id     (if_id)
  );

  // Processing
  mips_decode decode0 (
    .clk      (clk),
    .reset    (reset),
    .if_id    (if_id),
    .wb       (wb),
    .redirect (redirect),
    .id_ex    (id_ex),
    .stall    (stall)
  );

  mips_execute execute0 (
    .clk      (clk),
    .reset    (reset),
    .id_ex    (id_ex),
    .wb       (wb),
    .ex_mem   (ex_mem),
    .redirect (redirect)
  );

  // ----------------------------------------
  // Output side
  // ----------------------------------------
  assign dmem_addr  = ex_mem.alu_result;
  assign dmem_wdata = ex_mem.store_data;
  assign dmem_write = ex_mem.mem_write;

  mips_writeback writeback0 (
    .clk        (clk),
    .reset      (reset),
    .ex_mem     (ex_mem),
    .dmem_rdata (dmem_rdata),
    .wb         (wb)
  );

endmodule

//--- rtl/mips_writeback.sv
`timescale 1ns/1ps

module mips_writeback
  import mips_isa_pkg::*, mips_pipe_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  ex_mem_t  ex_mem,
  input  word_t    dmem_rdata,
  output wb_port_t wb
);

  logic     mw_reg_write;
  logic     mw_mem_to_reg;
  reg_idx_t mw_rd;
  word_t    mw_alu;
  word_t    mw_load;

  // MEM/WB register
  always_ff @(posedge clk) begin
    if (reset) begin
      mw_reg_write  <= 1'b0;
      mw_mem_to_reg <= 1'b0;
      mw_rd         <= '0;
      mw_alu        <= '0;
      mw_load       <= '0;
    end else begin
      mw_reg_write  <= ex_mem.reg_write;
      mw_mem_to_reg <= ex_mem.mem_to_reg;
      mw_rd         <= ex_mem.rd;
      mw_alu        <= ex_mem.alu_result;
      mw_load       <= dmem_rdata;           // Load data captured here
    end
  end

  // Register write port
  assign wb.we   = mw_reg_write;
  assign wb.rd   = mw_rd;
  assign wb.data = mw_mem_to_reg ? mw_load : mw_alu;

endmodule

//--- rtl/mips_execute.sv
`timescale 1ns/1ps

module mips_execute
  import mips_isa_pkg::*, mips_pipe_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  id_ex_t    id_ex,
  input  wb_port_t  wb,
  output ex_mem_t   ex_mem,
  output redirect_t redirect
);

  word_t    src_a;
  word_t    fwd_b;                // Also the store data
  word_t    src_b;
  word_t    alu_y;
  logic     zero;
  reg_idx_t dest;

  // ----------------------------------------
  // Forwarding, memory stage first
  // ----------------------------------------
  function automatic word_t forward(reg_idx_t src, word_t reg_val,
                                    ex_mem_t mem, wb_port_t w);
    word_t val;
    val = reg_val;
    if (mem.reg_write && mem.rd != '0 && mem.rd == src) begin
      val = mem.alu_result;
    end else if (w.we && w.rd != '0 && w.rd == src) begin
      val = w.data;
    end
    return val;
  endfunction

  assign src_a = forward(id_ex.rs, id_ex.rs_val, ex_mem, wb);
  assign fwd_b = forward(id_ex.rt, id_ex.rt_val, ex_mem, wb);
  assign src_b = id_ex.ctrl.alu_src ? id_ex.imm : fwd_b;

  // ALU
  always_comb begin
    case (id_ex.ctrl.alu_ctrl)
      alu_and:  alu_y = src_a & src_b;
      alu_or:   alu_y = src_a | src_b;
      alu_add:  alu_y = src_a + src_b;
      alu_sub:  alu_y = src_a - src_b;
      alu_slt:  alu_y = {{($bits(word_t) - 1){1'b0}}, $signed(src_a) < $signed(src_b)};
      alu_sltu: alu_y = {{($bits(word_t) - 1){1'b0}}, src_a < src_b};
      default:  alu_y = '0;
    endcase
  end

  assign zero = (alu_y == '0);

  // ----------------------------------------
  // Branch resolution
  // ----------------------------------------
  // beq takes on zero, bne on nonzero
  assign redirect.taken  = id_ex.ctrl.branch && (zero != id_ex.ctrl.branch_ne);
  assign redirect.target = id_ex.pc_plus4 + {id_ex.imm[$bits(word_t)-3:0], 2'b00};

  assign dest = id_ex.ctrl.reg_dst ? id_ex.rd : id_ex.rt;

  // EX/MEM register
  always_ff @(posedge clk) begin
    if (reset) begin
      ex_mem <= '0;
    end else begin
      ex_mem.reg_write  <= id_ex.ctrl.reg_write;
      ex_mem.mem_to_reg <= id_ex.ctrl.mem_to_reg;
      ex_mem.mem_write  <= id_ex.ctrl.mem_write;   // One-cycle store strobe
      ex_mem.alu_result <= alu_y;
      ex_mem.store_data <= fwd_b;
      ex_mem.rd         <= dest;
    end
  end

endmodule

//--- rtl/mips_decode.sv
`timescale 1ns/1ps

module mips_decode
  import mips_isa_pkg::*, mips_pipe_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  if_id_t    if_id,
  input  wb_port_t  wb,
  input  redirect_t redirect,
  output id_ex_t    id_ex,
  output logic      stall
);

  opcode_t   opcode;
  funct_t    funct;
  reg_idx_t  rs;
  reg_idx_t  rt;
  reg_idx_t  rd;
  imm_t      imm;
  word_t     imm_ext;
  logic      zero_ext;
  logic      funct_ok;
  alu_ctrl_t alu_op;
  ctrl_t     ctrl;
  word_t     rs_val;
  word_t     rt_val;
  word_t     regs [32];

  assign opcode = if_id.instr[op_lsb +: $bits(opcode_t)];
  assign funct  = if_id.instr[funct_lsb +: $bits(funct_t)];
  assign rs     = if_id.instr[rs_lsb +: $bits(reg_idx_t)];
  assign rt     = if_id.instr[rt_lsb +: $bits(reg_idx_t)];
  assign rd     = if_id.instr[rd_lsb +: $bits(reg_idx_t)];
  assign imm    = if_id.instr[imm_lsb +: imm_width];

  // ----------------------------------------
  // ALU decoder
  // ----------------------------------------
  always_comb begin
    funct_ok = 1'b1;
    alu_op   = alu_add;                 // Loads, stores, addi
    if (opcode == op_ori) begin
      alu_op = alu_or;
    end else if (opcode == op_slti) begin
      alu_op = alu_slt;
    end else if (opcode == op_beq || opcode == op_bne) begin
      alu_op = alu_sub;                 // Compare by subtraction
    end else if (opcode == op_rtype) begin
      case (funct)
        funct_add, funct_addu: alu_op = alu_add;
        funct_sub, funct_subu: alu_op = alu_sub;
        funct_and:             alu_op = alu_and;
        funct_or:              alu_op = alu_or;
        funct_slt:             alu_op = alu_slt;
        funct_sltu:            alu_op = alu_sltu;
        default:               funct_ok = 1'b0;
      endcase
    end
  end

  // Main decoder, anything unknown stays a bubble
  always_comb begin
    ctrl     = '0;
    zero_ext = 1'b0;
    case (opcode)
      op_rtype: begin
        ctrl.reg_write = funct_ok;
        ctrl.reg_dst   = 1'b1;
      end
      op_lw: begin
        ctrl.reg_write  = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.alu_src    = 1'b1;
      end
      op_sw: begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_src   = 1'b1;
      end
      op_beq:  ctrl.branch = 1'b1;
      op_bne: begin
        ctrl.branch    = 1'b1;
        ctrl.branch_ne = 1'b1;
      end
      op_addi, op_addiu, op_slti: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
      end
      op_ori: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        zero_ext       = 1'b1;
      end
      default: ctrl = '0;
    endcase
    if (ctrl != '0) begin
      ctrl.alu_ctrl = alu_op;
    end
  end

  assign imm_ext = zero_ext ? {{($bits(word_t) - imm_width){1'b0}}, imm}
                            : {{($bits(word_t) - imm_width){imm[imm_width-1]}}, imm};

  // ----------------------------------------
  // Register file
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (wb.we && wb.rd != '0) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // Write-through from writeback, r0 hardwired
  assign rs_val = (rs == '0) ? '0 : (wb.we && wb.rd == rs) ? wb.data : regs[rs];
  assign rt_val = (rt == '0) ? '0 : (wb.we && wb.rd == rt) ? wb.data : regs[rt];

  // Load in execute feeding this instruction
  assign stall = id_ex.ctrl.mem_to_reg && id_ex.rt != '0 &&
                 (id_ex.rt == rs || id_ex.rt == rt);

  // ID/EX register
  always_ff @(posedge clk) begin
    if (reset) begin
      id_ex <= '0;
    end else begin
      id_ex.ctrl     <= (stall || redirect.taken) ? '0 : ctrl;
      id_ex.pc_plus4 <= if_id.pc_plus4;
      id_ex.rs_val   <= rs_val;
      id_ex.rt_val   <= rt_val;
      id_ex.imm      <= imm_ext;
      id_ex.rs       <= rs;
      id_ex.rt       <= rt;
      id_ex.rd       <= rd;
    end
  end

endmodule

//--- rtl/mips_fetch.sv
`timescale 1ns/1ps

module mips_fetch
  import mips_isa_pkg::*, mips_pipe_pkg::*;
#(
  parameter word_t reset_pc = '0
) (
  input  logic      clk,
  input  logic      reset,
  input  logic      stall,
  input  redirect_t redirect,
  input  instr_t    imem_data,
  output word_t     imem_addr,
  output if_id_t    if_id
);

  word_t pc;
  word_t pc_plus4;

  assign pc_plus4  = pc + pc_step;
  assign imem_addr = pc;

  // PC register, a taken branch wins over a load-use stall
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= reset_pc;
    end else if (redirect.taken) begin
      pc <= redirect.target;
    end else if (!stall) begin
      pc <= pc_plus4;
    end
  end

  // ----------------------------------------
  // IF/ID register
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      if_id <= '0;
    end else if (redirect.taken) begin
      if_id <= '0;                       // Squash wrong-path fetch
    end else if (!stall) begin
      if_id.instr    <= imem_data;
      if_id.pc_plus4 <= pc_plus4;
    end
  end

endmodule

//--- rtl/mips_pipe_pkg.sv
package mips_pipe_pkg;

  import mips_isa_pkg::*;

  // ----------------------------------------
  // ALU operation codes
  // ----------------------------------------
  typedef logic [2:0] alu_ctrl_t;

  localparam alu_ctrl_t alu_and  = 3'b000;
  localparam alu_ctrl_t alu_or   = 3'b001;
  localparam alu_ctrl_t alu_add  = 3'b010;
  localparam alu_ctrl_t alu_sltu = 3'b011;  // Unsigned compare
  localparam alu_ctrl_t alu_sub  = 3'b110;
  localparam alu_ctrl_t alu_slt  = 3'b111;

  // All zero is a bubble
  typedef struct packed {
    logic      reg_write;
    logic      mem_to_reg;   // Load result goes to the register file
    logic      mem_write;
    logic      branch;
    logic      branch_ne;    // bne rather than beq
    logic      alu_src;      // Immediate as second operand
    logic      reg_dst;      // rd rather than rt
    alu_ctrl_t alu_ctrl;
  } ctrl_t;

  // ----------------------------------------
  // Pipeline registers
  // ----------------------------------------
  typedef struct packed {
    instr_t instr;
    word_t  pc_plus4;
  } if_id_t;

  typedef struct packed {
    ctrl_t    ctrl;
    word_t    pc_plus4;
    word_t    rs_val;
    word_t    rt_val;
    word_t    imm;           // Already extended
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;
  } id_ex_t;

  typedef struct packed {
    logic     reg_write;
    logic     mem_to_reg;
    logic     mem_write;
    word_t    alu_result;
    word_t    store_data;
    reg_idx_t rd;
  } ex_mem_t;

  typedef struct packed {
    logic     we;
    reg_idx_t rd;
    word_t    data;
  } wb_port_t;

  typedef struct packed {
    logic  taken;
    word_t target;
  } redirect_t;

endpackage

//--- rtl/mips_isa_pkg.sv
package mips_isa_pkg;

  typedef logic [31:0] word_t;     // Data and address word
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [5:0]  funct_t;
  typedef logic [15:0] imm_t;

  // ----------------------------------------
  // Instruction field positions
  // ----------------------------------------
  localparam int op_lsb    = 26;
  localparam int rs_lsb    = 21;
  localparam int rt_lsb    = 16;
  localparam int rd_lsb    = 11;
  localparam int imm_lsb   = 0;
  localparam int imm_width = 16;
  localparam int funct_lsb = 0;

  // Opcodes
  localparam opcode_t op_rtype = 6'b000000;
  localparam opcode_t op_lw    = 6'b100011;
  localparam opcode_t op_sw    = 6'b101011;
  localparam opcode_t op_beq   = 6'b000100;
  localparam opcode_t op_bne   = 6'b000101;
  localparam opcode_t op_addi  = 6'b001000;
  localparam opcode_t op_addiu = 6'b001001;
  localparam opcode_t op_ori   = 6'b001101;
  localparam opcode_t op_slti  = 6'b001010;

  // R-type function codes
  localparam funct_t funct_add  = 6'b100000;
  localparam funct_t funct_addu = 6'b100001;
  localparam funct_t funct_sub  = 6'b100010;
  localparam funct_t funct_subu = 6'b100011;
  localparam funct_t funct_and  = 6'b100100;
  localparam funct_t funct_or   = 6'b100101;
  localparam funct_t funct_slt  = 6'b101010;
  localparam funct_t funct_sltu = 6'b101011;

  localparam word_t pc_step = 32'd4;  // Bytes per instruction

endpackage
